//--- rtl/feeder_pkg.sv
`default_nettype none

package feeder_pkg;

    // ####################
    // bus and line geometry
    // ####################
    parameter int XLEN = 32;
    parameter int LINE_BYTES = 64;
    parameter int LINE_BITS = 512;
    parameter int HALF_BITS = 256;
    parameter int WORDS_PER_LINE = 32;

    // index widths derived from the line size
    parameter int LINE_OFS_BITS = $clog2(LINE_BYTES);
    parameter int WORD_IDX_BITS = $clog2(WORDS_PER_LINE);

    // ####################
    // register map
    // ####################
    parameter logic [XLEN-1:0] CMD_ADDR        = 32'hC400_0000;
    parameter logic [XLEN-1:0] PARAM1_ADDR     = 32'hC400_0004;
    parameter logic [XLEN-1:0] PARAM2_ADDR     = 32'hC400_0008;
    parameter logic [XLEN-1:0] BUSY_ADDR       = 32'hC400_0020;
    parameter logic [XLEN-1:0] RD_ADDR_ADDR    = 32'hC400_2024;
    parameter logic [XLEN-1:0] RD_LEN_ADDR     = 32'hC400_2028;
    parameter logic [XLEN-1:0] START_ADDR      = 32'hC400_2030;
    parameter logic [XLEN-1:0] OFFSET_CLR_ADDR = 32'hC400_2034;
    parameter logic [XLEN-1:0] KIND_ADDR       = 32'hC400_2038;

    // engine load commands
    parameter int CMD_LOAD_INPUT = 9;
    parameter int CMD_LOAD_WEIGHT = 10;

    // ####################
    // word placement in a line
    // ####################

    // words 0-15 sit in the low half, 16-31 in the high half;
    // inside a half the words run from the top down in swapped pairs
    function automatic logic [WORD_IDX_BITS-1:0] word_slot(
        input logic [WORD_IDX_BITS-1:0] n
    );
        logic [WORD_IDX_BITS-2:0] m;
        logic [WORD_IDX_BITS-2:0] pos;
        m = n[WORD_IDX_BITS-2:0];
        pos = (~m) ^ 1;
        return {n[WORD_IDX_BITS-1], pos};
    endfunction

endpackage

`default_nettype wire

//--- rtl/feeder_regs.sv
`timescale 1ns/100ps
`default_nettype none

module feeder_regs #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_BITS = 15,
    parameter int CMD_WIDTH = 8
) (
    input  wire                           clk_i,
    input  wire                           rst_i,

    // cpu bus
    input  wire                           strobe_i,
    input  wire  [feeder_pkg::XLEN-1:0]   addr_i,
    input  wire                           rw_i,
    input  wire  [feeder_pkg::XLEN-1:0]   data_i,
    output logic                          ready_o,
    output logic [feeder_pkg::XLEN-1:0]   data_o,

    // word stream from the unpacker
    input  wire                           emit_valid_i,
    input  wire  [DATA_WIDTH-1:0]         emit_word_i,
    input  wire  [DATA_WIDTH-1:0]         emit_index_i,

    input  wire                           req_busy_i,
    input  wire                           unpack_busy_i,

    // transfer configuration
    output logic [feeder_pkg::XLEN-1:0]   rd_base_o,
    output logic [ADDR_BITS-1:0]          rd_len_o,
    output logic                          start_o,
    output logic                          offset_clr_o,

    // engine command
    output logic                          cmd_valid_o,
    output logic [CMD_WIDTH-1:0]          cmd_o,
    output logic [DATA_WIDTH-1:0]         param1_o,
    output logic [DATA_WIDTH-1:0]         param2_o
);

    logic kind_q;
    logic busy;
    logic [CMD_WIDTH-1:0] load_code;

    // ####################
    // bus response
    // ####################
    assign busy = req_busy_i | unpack_busy_i | cmd_valid_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ready_o <= 1'b0;
        end else begin
            ready_o <= strobe_i;
        end
    end

    // only the busy flag is readable
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            data_o <= '0;
        end else if (strobe_i && !rw_i && addr_i == feeder_pkg::BUSY_ADDR) begin
            data_o <= {{(feeder_pkg::XLEN-1){1'b0}}, busy};
        end
    end

    // ####################
    // transfer setup
    // ####################
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_base_o <= '0;
            rd_len_o <= '0;
            kind_q <= 1'b0;
        end else if (strobe_i) begin
            if (addr_i == feeder_pkg::RD_ADDR_ADDR)
                rd_base_o <= data_i;
            if (addr_i == feeder_pkg::RD_LEN_ADDR)
                rd_len_o <= data_i[ADDR_BITS-1:0];
            if (addr_i == feeder_pkg::KIND_ADDR)
                kind_q <= data_i[0];
        end
    end

    // one-cycle pulses straight from the strobe
    assign start_o = strobe_i && addr_i == feeder_pkg::START_ADDR;
    assign offset_clr_o = strobe_i && addr_i == feeder_pkg::OFFSET_CLR_ADDR;

    // 0 loads input, 1 loads weight
    assign load_code = kind_q ? CMD_WIDTH'(feeder_pkg::CMD_LOAD_WEIGHT)
                              : CMD_WIDTH'(feeder_pkg::CMD_LOAD_INPUT);

    // ####################
    // engine command register
    // ####################
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cmd_valid_o <= 1'b0;
            cmd_o <= '0;
            param1_o <= '0;
            param2_o <= '0;
        end else begin
            cmd_valid_o <= 1'b0;
            if (strobe_i && addr_i == feeder_pkg::CMD_ADDR) begin
                // software command goes out with the current params
                cmd_valid_o <= 1'b1;
                cmd_o <= data_i[CMD_WIDTH-1:0];
            end else if (strobe_i && addr_i == feeder_pkg::PARAM1_ADDR) begin
                param1_o <= data_i[DATA_WIDTH-1:0];
            end else if (strobe_i && addr_i == feeder_pkg::PARAM2_ADDR) begin
                param2_o <= data_i[DATA_WIDTH-1:0];
            end else if (emit_valid_i) begin
                cmd_valid_o <= 1'b1;
                cmd_o <= load_code;
                param1_o <= emit_word_i;
                param2_o <= emit_index_i;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/dram_req_gen.sv
`timescale 1ns/100ps
`default_nettype none

module dram_req_gen #(
    parameter int ADDR_BITS = 15
) (
    input  wire                          clk_i,
    input  wire                          rst_i,

    input  wire                          start_i,
    input  wire  [feeder_pkg::XLEN-1:0]  rd_base_i,
    input  wire  [ADDR_BITS-1:0]         rd_len_i,

    input  wire                          fifo_addr_full_i,
    input  wire                          dram_rw_full_i,

    output logic                         dram_addr_valid_o,
    output logic [feeder_pkg::XLEN-1:0]  dram_addr_o,
    output logic                         rw_o,

    output logic                         busy_o
);

    localparam int OFS = feeder_pkg::LINE_OFS_BITS;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_SPACE,
        SEND
    } state_t;

    state_t state_q;
    logic [feeder_pkg::XLEN-1:0] addr_q;
    logic [ADDR_BITS-1:0] cnt_q;
    logic space;
    logic [OFS:0] step;
    logic [ADDR_BITS:0] covered;
    logic last_req;

    assign space = !fifo_addr_full_i && !dram_rw_full_i;

    // bytes up to the next line boundary, and words counted for them
    assign step = (OFS+1)'(feeder_pkg::LINE_BYTES) - {1'b0, addr_q[OFS-1:0]};
    assign covered = {1'b0, cnt_q} + (ADDR_BITS+1)'(step[OFS:1]);
    assign last_req = covered >= {1'b0, rd_len_i};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            addr_q <= '0;
            cnt_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        addr_q <= rd_base_i;
                        cnt_q <= '0;
                        state_q <= WAIT_SPACE;
                    end
                end
                WAIT_SPACE: begin
                    if (space)
                        state_q <= SEND;
                end
                SEND: begin
                    // hold here if the fifos filled up meanwhile
                    if (space) begin
                        addr_q <= addr_q + feeder_pkg::XLEN'(step);
                        cnt_q <= covered[ADDR_BITS-1:0];
                        state_q <= last_req ? IDLE : WAIT_SPACE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign dram_addr_valid_o = (state_q == SEND) && space;
    assign dram_addr_o = addr_q;
    // 0 marks a read
    assign rw_o = !dram_addr_valid_o;
    assign busy_o = state_q != IDLE;

endmodule

`default_nettype wire

//--- rtl/line_unpacker.sv
`timescale 1ns/100ps
`default_nettype none

module line_unpacker #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_BITS = 15
) (
    input  wire                               clk_i,
    input  wire                               rst_i,

    input  wire                               start_i,
    input  wire  [feeder_pkg::XLEN-1:0]       rd_base_i,
    input  wire  [ADDR_BITS-1:0]              rd_len_i,
    input  wire                               offset_clr_i,

    // read data fifo
    input  wire                               fifo_data_empty_i,
    input  wire  [feeder_pkg::HALF_BITS-1:0]  dram_read_data_h_i,
    input  wire  [feeder_pkg::HALF_BITS-1:0]  dram_read_data_l_i,
    output logic                              fifo_data_rd_en_o,

    // one word per cycle towards the engine
    output logic                              emit_valid_o,
    output logic [DATA_WIDTH-1:0]             emit_word_o,
    output logic [DATA_WIDTH-1:0]             emit_index_o,

    output logic                              busy_o
);

    localparam int OFS = feeder_pkg::LINE_OFS_BITS;
    localparam int IDX = feeder_pkg::WORD_IDX_BITS;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_DATA,
        EMIT,
        POP
    } state_t;

    state_t state_q;
    logic [feeder_pkg::LINE_BITS-1:0] line_q;
    logic [feeder_pkg::XLEN-1:0] addr_q;
    logic [ADDR_BITS-1:0] sent_q;
    logic [ADDR_BITS-1:0] sent_next;
    logic [DATA_WIDTH-1:0] offset_q;
    logic [IDX-1:0] word_idx;
    logic [IDX-1:0] slot;
    logic line_end;
    logic xfer_end;
    logic capture;

    assign word_idx = addr_q[OFS-1:1];
    assign slot = feeder_pkg::word_slot(word_idx);
    assign sent_next = sent_q + 1'b1;

    // stop at the line's last word or the transfer's last word
    assign line_end = word_idx == IDX'(feeder_pkg::WORDS_PER_LINE - 1);
    assign xfer_end = sent_next == rd_len_i;
    assign capture = (state_q == WAIT_DATA) && !fifo_data_empty_i;

    // ####################
    // control
    // ####################
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            addr_q <= '0;
            sent_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        addr_q <= rd_base_i;
                        sent_q <= '0;
                        state_q <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (!fifo_data_empty_i)
                        state_q <= EMIT;
                end
                EMIT: begin
                    addr_q <= addr_q + 2;
                    sent_q <= sent_next;
                    if (line_end || xfer_end)
                        state_q <= POP;
                end
                POP: begin
                    state_q <= (sent_q == rd_len_i) ? IDLE : WAIT_DATA;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // scratchpad offset carries over between transfers
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            offset_q <= '0;
        end else if (offset_clr_i) begin
            offset_q <= '0;
        end else if (state_q == EMIT) begin
            offset_q <= offset_q + 1'b1;
        end
    end

    // ####################
    // line buffer
    // ####################
    always_ff @(posedge clk_i) begin
        if (capture)
            line_q <= {dram_read_data_h_i, dram_read_data_l_i};
    end

    assign emit_valid_o = state_q == EMIT;
    assign emit_word_o = line_q[slot*DATA_WIDTH +: DATA_WIDTH];
    assign emit_index_o = offset_q;
    assign fifo_data_rd_en_o = state_q == POP;
    assign busy_o = state_q != IDLE;

endmodule

`default_nettype wire

//--- rtl/data_feeder.sv
`timescale 1ns/100ps
`default_nettype none

module data_feeder #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_BITS = 15,
    parameter int CMD_WIDTH = 8
) (
    input  wire                               clk_i,
    input  wire                               rst_i,

    // cpu bus
    input  wire                               strobe_i,
    input  wire  [feeder_pkg::XLEN-1:0]       addr_i,
    input  wire                               rw_i,
    input  wire  [feeder_pkg::XLEN-1:0]       data_i,
    output logic                              ready_o,
    output logic [feeder_pkg::XLEN-1:0]       data_o,

    // dram request fifos
    input  wire                               fifo_addr_full_i,
    input  wire                               dram_rw_full_i,
    output logic                              dram_addr_valid_o,
    output logic [feeder_pkg::XLEN-1:0]       dram_addr_o,
    output logic                              rw_o,

    // dram read data fifo
    input  wire                               fifo_data_empty_i,
    input  wire  [feeder_pkg::HALF_BITS-1:0]  dram_read_data_h_i,
    input  wire  [feeder_pkg::HALF_BITS-1:0]  dram_read_data_l_i,
    output logic                              fifo_data_rd_en_o,

    // engine command
    output logic                              cmd_valid_o,
    output logic [CMD_WIDTH-1:0]              cmd_o,
    output logic [DATA_WIDTH-1:0]             param1_o,
    output logic [DATA_WIDTH-1:0]             param2_o
);

    logic [feeder_pkg::XLEN-1:0] rd_base;
    logic [ADDR_BITS-1:0] rd_len;
    logic start;
    logic offset_clr;
    logic emit_valid;
    logic [DATA_WIDTH-1:0] emit_word;
    logic [DATA_WIDTH-1:0] emit_index;
    logic req_busy;
    logic unpack_busy;

    feeder_regs #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_BITS(ADDR_BITS),
        .CMD_WIDTH(CMD_WIDTH)
    ) feeder_regs_i (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .strobe_i(strobe_i),
        .addr_i(addr_i),
        .rw_i(rw_i),
        .data_i(data_i),
        .ready_o(ready_o),
        .data_o(data_o),
        .emit_valid_i(emit_valid),
        .emit_word_i(emit_word),
        .emit_index_i(emit_index),
        .req_busy_i(req_busy),
        .unpack_busy_i(unpack_busy),
        .rd_base_o(rd_base),
        .rd_len_o(rd_len),
        .start_o(start),
        .offset_clr_o(offset_clr),
        .cmd_valid_o(cmd_valid_o),
        .cmd_o(cmd_o),
        .param1_o(param1_o),
        .param2_o(param2_o)
    );

    dram_req_gen #(
        .ADDR_BITS(ADDR_BITS)
    ) dram_req_gen_i (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .start_i(start),
        .rd_base_i(rd_base),
        .rd_len_i(rd_len),
        .fifo_addr_full_i(fifo_addr_full_i),
        .dram_rw_full_i(dram_rw_full_i),
        .dram_addr_valid_o(dram_addr_valid_o),
        .dram_addr_o(dram_addr_o),
        .rw_o(rw_o),
        .busy_o(req_busy)
    );

    line_unpacker #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_BITS(ADDR_BITS)
    ) line_unpacker_i (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .start_i(start),
        .rd_base_i(rd_base),
        .rd_len_i(rd_len),
        .offset_clr_i(offset_clr),
        .fifo_data_empty_i(fifo_data_empty_i),
        .dram_read_data_h_i(dram_read_data_h_i),
        .dram_read_data_l_i(dram_read_data_l_i),
        .fifo_data_rd_en_o(fifo_data_rd_en_o),
        .emit_valid_o(emit_valid),
        .emit_word_o(emit_word),
        .emit_index_o(emit_index),
        .busy_o(unpack_busy)
    );

endmodule

`default_nettype wire

//--- tests/data_feeder_props.sv
`timescale 1ns/100ps
`default_nettype none

module data_feeder_props (
    input wire clk_i,
    input wire rst_i,
    input wire strobe_i,
    input wire ready_i,
    input wire addr_full_i,
    input wire rw_full_i,
    input wire addr_valid_i,
    input wire data_empty_i,
    input wire rd_en_i
);

    // bus answers every strobe in the next cycle, and only then
    ready_follows_strobe: assert property (
        @(posedge clk_i) disable iff (rst_i) ready_i == $past(strobe_i)
    ) else $error("ready_o does not follow strobe_i by one cycle");

    no_request_when_full: assert property (
        @(posedge clk_i) disable iff (rst_i) addr_valid_i |-> !(addr_full_i || rw_full_i)
    ) else $error("read request issued while a request FIFO is full");

    no_pop_when_empty: assert property (
        @(posedge clk_i) disable iff (rst_i) rd_en_i |-> !data_empty_i
    ) else $error("read data FIFO popped while empty");

endmodule

bind data_feeder data_feeder_props data_feeder_props_i (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .strobe_i(strobe_i),
    .ready_i(ready_o),
    .addr_full_i(fifo_addr_full_i),
    .rw_full_i(dram_rw_full_i),
    .addr_valid_i(dram_addr_valid_o),
    .data_empty_i(fifo_data_empty_i),
    .rd_en_i(fifo_data_rd_en_o)
);

`default_nettype wire

//--- tests/tb_data_feeder.sv
`timescale 1ns/100ps
`default_nettype none

module tb_data_feeder;

    localparam int DATA_WIDTH = 16;
    localparam int ADDR_BITS = 15;
    localparam int CMD_WIDTH = 8;
    localparam int XLEN = feeder_pkg::XLEN;
    localparam int LBITS = feeder_pkg::LINE_BITS;
    localparam int NUM_XFERS = 12;
    localparam int FIFO_DEPTH = 4;

    logic clk_i = 1'b0;
    logic rst_i = 1'b1;
    logic strobe_i = 1'b0;
    logic [XLEN-1:0] addr_i = '0;
    logic rw_i = 1'b0;
    logic [XLEN-1:0] data_i = '0;
    logic ready_o;
    logic [XLEN-1:0] data_o;
    logic fifo_addr_full_i = 1'b0;
    logic dram_rw_full_i = 1'b0;
    logic dram_addr_valid_o;
    logic [XLEN-1:0] dram_addr_o;
    logic rw_o;
    logic fifo_data_empty_i = 1'b1;
    logic [feeder_pkg::HALF_BITS-1:0] dram_read_data_h_i = '0;
    logic [feeder_pkg::HALF_BITS-1:0] dram_read_data_l_i = '0;
    logic fifo_data_rd_en_o;
    logic cmd_valid_o;
    logic [CMD_WIDTH-1:0] cmd_o;
    logic [DATA_WIDTH-1:0] param1_o;
    logic [DATA_WIDTH-1:0] param2_o;

    // random source and model state
    logic [31:0] lfsr_q = 32'he804_3a06;
    int cyc = 0;
    int sw_due = -1;
    int wd_limit = 0;
    int lines_req = 0;
    int pops = 0;
    int m_left = 0;
    logic strobe_q = 1'b0;
    logic [XLEN-1:0] m_base = '0;
    logic [ADDR_BITS-1:0] m_len = '0;
    logic m_kind = 1'b0;
    logic [DATA_WIDTH-1:0] m_offset = '0;
    logic [DATA_WIDTH-1:0] m_p1 = '0;
    logic [DATA_WIDTH-1:0] m_p2 = '0;
    logic [XLEN-1:0] exp_req[$];
    logic [XLEN-1:0] pend_addr[$];
    int pend_due[$];
    logic [LBITS-1:0] line_fifo[$];
    logic [CMD_WIDTH-1:0] exp_code[$];
    logic [DATA_WIDTH-1:0] exp_p1[$];
    logic [DATA_WIDTH-1:0] exp_p2[$];

    data_feeder #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_BITS(ADDR_BITS),
        .CMD_WIDTH(CMD_WIDTH)
    ) data_feeder_i (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .strobe_i(strobe_i),
        .addr_i(addr_i),
        .rw_i(rw_i),
        .data_i(data_i),
        .ready_o(ready_o),
        .data_o(data_o),
        .fifo_addr_full_i(fifo_addr_full_i),
        .dram_rw_full_i(dram_rw_full_i),
        .dram_addr_valid_o(dram_addr_valid_o),
        .dram_addr_o(dram_addr_o),
        .rw_o(rw_o),
        .fifo_data_empty_i(fifo_data_empty_i),
        .dram_read_data_h_i(dram_read_data_h_i),
        .dram_read_data_l_i(dram_read_data_l_i),
        .fifo_data_rd_en_o(fifo_data_rd_en_o),
        .cmd_valid_o(cmd_valid_o),
        .cmd_o(cmd_o),
        .param1_o(param1_o),
        .param2_o(param2_o)
    );

    initial begin
        forever #2 clk_i = ~clk_i;
    end

    // ####################
    // helpers
    // ####################

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [LBITS-1:0] random_line();
        logic [LBITS-1:0] l;
        for (int i = 0; i < LBITS / 32; i++) begin
            l[i*32 +: 32] = rand_bits(32);
        end
        return l;
    endfunction

    // word n of a line counted from the top of its half in swapped pairs
    function automatic logic [DATA_WIDTH-1:0] pick_word(input logic [LBITS-1:0] line, input int n);
        int slot;
        slot = (n / 16) * 16 + ((15 - (n % 16)) ^ 1);
        return line[slot*DATA_WIDTH +: DATA_WIDTH];
    endfunction

    task automatic report_error(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_addr(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp)
            report_error($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp)
            report_error($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_cmd(input string name,
                             input logic [CMD_WIDTH-1:0] exp_c,
                             input logic [DATA_WIDTH-1:0] exp_a,
                             input logic [DATA_WIDTH-1:0] exp_b);
        if (cmd_o !== exp_c || param1_o !== exp_a || param2_o !== exp_b)
            report_error($sformatf(
                "mismatch %s: expected cmd %0d p1 %h p2 %h, actual cmd %0d p1 %h p2 %h",
                name, exp_c, exp_a, exp_b, cmd_o, param1_o, param2_o));
    endtask

    // one request per line touched until half the bytes cover the length
    task automatic plan_requests();
        logic [XLEN-1:0] a;
        int covered;
        int step;
        a = m_base;
        covered = 0;
        do begin
            exp_req.push_back(a);
            step = feeder_pkg::LINE_BYTES - int'(a[5:0]);
            covered += step / 2;
            a = a + XLEN'(step);
        end while (covered < int'(m_len));
        m_left = int'(m_len);
    endtask

    task automatic expand_line(input logic [XLEN-1:0] addr, input logic [LBITS-1:0] line);
        int idx;
        idx = int'(addr[5:1]);
        while (idx < feeder_pkg::WORDS_PER_LINE && m_left > 0) begin
            exp_code.push_back(m_kind ? CMD_WIDTH'(feeder_pkg::CMD_LOAD_WEIGHT)
                                      : CMD_WIDTH'(feeder_pkg::CMD_LOAD_INPUT));
            exp_p1.push_back(pick_word(line, idx));
            exp_p2.push_back(m_offset);
            m_offset = m_offset + 1'b1;
            m_left--;
            idx++;
        end
    endtask

    task automatic track_register_write();
        case (addr_i)
            feeder_pkg::RD_ADDR_ADDR: m_base = data_i;
            feeder_pkg::RD_LEN_ADDR: m_len = data_i[ADDR_BITS-1:0];
            feeder_pkg::KIND_ADDR: m_kind = data_i[0];
            feeder_pkg::OFFSET_CLR_ADDR: m_offset = '0;
            feeder_pkg::PARAM1_ADDR: m_p1 = data_i[DATA_WIDTH-1:0];
            feeder_pkg::PARAM2_ADDR: m_p2 = data_i[DATA_WIDTH-1:0];
            feeder_pkg::START_ADDR: plan_requests();
            feeder_pkg::CMD_ADDR: begin
                exp_code.push_back(data_i[CMD_WIDTH-1:0]);
                exp_p1.push_back(m_p1);
                exp_p2.push_back(m_p2);
                sw_due = cyc + 1;
            end
            default: ;
        endcase
    endtask

    // ####################
    // bus and dram model
    // ####################
    always @(posedge clk_i) begin
        logic [LBITS-1:0] line;
        if (!rst_i) begin
            cyc = cyc + 1;
            if (ready_o !== strobe_q)
                report_error("ready_o was not high exactly one cycle after a strobe");
            strobe_q = strobe_i;
            if (strobe_i)
                track_register_write();
            if (sw_due == cyc && cmd_valid_o !== 1'b1)
                report_error("software command did not appear one cycle after the CMD write");
            if (cmd_valid_o === 1'b1) begin
                if (exp_code.size() == 0)
                    report_error("engine command seen while none was expected");
                check_cmd(sw_due == cyc ? "software command" : "load command",
                          exp_code.pop_front(), exp_p1.pop_front(), exp_p2.pop_front());
            end
            if (dram_addr_valid_o === 1'b1) begin
                if (fifo_addr_full_i || dram_rw_full_i)
                    report_error("read request issued while a request FIFO was full");
                if (rw_o !== 1'b0)
                    report_error("rw_o was not low during a read request");
                if (exp_req.size() == 0)
                    report_error("read request seen while none was expected");
                check_addr("request address", exp_req.pop_front(), dram_addr_o);
                pend_addr.push_back(dram_addr_o);
                pend_due.push_back(cyc + 1 + int'(rand_bits(3)));
                lines_req++;
            end
            if (fifo_data_rd_en_o === 1'b1) begin
                if (line_fifo.size() == 0)
                    report_error("line popped from an empty read data FIFO");
                void'(line_fifo.pop_front());
                pops++;
            end
            // lines come back in order after a random delay
            if (pend_due.size() != 0 && pend_due[0] <= cyc) begin
                line = random_line();
                line_fifo.push_back(line);
                expand_line(pend_addr.pop_front(), line);
                void'(pend_due.pop_front());
            end
            fifo_data_empty_i <= line_fifo.size() == 0;
            if (line_fifo.size() != 0) begin
                dram_read_data_h_i <= line_fifo[0][LBITS-1:LBITS/2];
                dram_read_data_l_i <= line_fifo[0][LBITS/2-1:0];
            end
            fifo_addr_full_i <= rand_bits(2) == 2'd0
                                || pend_due.size() + line_fifo.size() >= FIFO_DEPTH;
            dram_rw_full_i <= rand_bits(2) == 2'd0;
        end
    end

    // ####################
    // stimulus
    // ####################
    task automatic bus_write(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
        strobe_i <= 1'b1;
        addr_i <= addr;
        rw_i <= 1'b1;
        data_i <= data;
        @(posedge clk_i);
        strobe_i <= 1'b0;
        rw_i <= 1'b0;
        @(posedge clk_i);
    endtask

    task automatic bus_read(input logic [XLEN-1:0] addr, output logic [XLEN-1:0] data);
        strobe_i <= 1'b1;
        addr_i <= addr;
        rw_i <= 1'b0;
        @(posedge clk_i);
        strobe_i <= 1'b0;
        @(posedge clk_i);
        data = data_o;
    endtask

    task automatic wait_idle();
        logic [XLEN-1:0] rd;
        do begin
            bus_read(feeder_pkg::BUSY_ADDR, rd);
        end while (rd[0] === 1'b1);
        check_data("busy after transfer", 32'd0, rd);
    endtask

    task automatic software_command();
        bus_write(feeder_pkg::PARAM1_ADDR, rand_bits(16));
        bus_write(feeder_pkg::PARAM2_ADDR, rand_bits(16));
        bus_write(feeder_pkg::CMD_ADDR, rand_bits(8));
    endtask

    initial begin
        logic [XLEN-1:0] bases[NUM_XFERS];
        logic [XLEN-1:0] lens[NUM_XFERS];
        logic [XLEN-1:0] rd;
        int total;
        total = 0;
        // even bases that are mostly not line aligned
        for (int t = 0; t < NUM_XFERS; t++) begin
            bases[t] = 32'h1000_0000 + (rand_bits(15) << 1);
            lens[t] = 32'd1 + rand_bits(7) % 32'd100;
            total += int'(lens[t]);
        end
        wd_limit = 200 * total + 2000;
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;
        @(posedge clk_i);
        for (int t = 0; t < NUM_XFERS; t++) begin
            if (t == 5 || t == 9)
                bus_write(feeder_pkg::OFFSET_CLR_ADDR, 32'd0);
            bus_write(feeder_pkg::KIND_ADDR, rand_bits(1));
            bus_write(feeder_pkg::RD_ADDR_ADDR, bases[t]);
            bus_write(feeder_pkg::RD_LEN_ADDR, lens[t]);
            bus_write(feeder_pkg::START_ADDR, 32'd0);
            bus_read(feeder_pkg::BUSY_ADDR, rd);
            check_data("busy during transfer", 32'd1, rd);
            wait_idle();
            if (exp_code.size() != 0 || m_left != 0)
                report_error("transfer ended with load commands still missing");
            if (pops != lines_req || line_fifo.size() != 0)
                report_error("number of line pops differs from the lines requested");
            if (t % 4 == 3)
                software_command();
        end
        wait_idle();
        if (exp_code.size() == 0 && exp_req.size() == 0 && pops == lines_req) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            report_error("commands or requests left over at the end of the run");
        end
    end

    // watchdog sized from the total transfer length
    initial begin
        wait (wd_limit > 0);
        repeat (wd_limit) @(posedge clk_i);
        report_error("timeout, the run did not finish in the allowed cycles");
    end

endmodule

`default_nettype wire

//--- verilog.f
rtl/feeder_pkg.sv
rtl/feeder_regs.sv
rtl/dram_req_gen.sv
rtl/line_unpacker.sv
rtl/data_feeder.sv
tests/data_feeder_props.sv
tests/tb_data_feeder.sv

//--- Makefile
SIM      = verilator
TOP      = tb_data_feeder
FILELIST = verilog.f
FLAGS    = --binary --timing --assert -Wno-fatal
OBJDIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
